// ==== Makefile ====
# Verilator build and run of the radio core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_x300_radio_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := >>> FAIL

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log for failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_x300_radio_core.sv ====
`timescale 1ns/100ps
`include "radio_params.svh"

module tb_x300_radio_core;

   localparam int NB           = `RADIO_NUM_DBOARDS;
   localparam int CYCLES       = 400;
   localparam int IDLE_TIMEOUT = 8;

   typedef enum int {MODE_IDLE, MODE_SET, MODE_RB, MODE_FE, MODE_FP} mode_e;

   logic                      radio_clk;
   logic                      i_rst_n;
   radio_pkg::set_bus_t       set_in [NB];
   radio_pkg::rb_req_t        rb_req [NB];
   logic [NB-1:0]             run_rx, run_tx, rx_stb, tx_stb;
   logic [31:0]               rx_in [NB], tx_in [NB], gpio_in [NB], misc_in [NB];
   radio_pkg::rb_resp_t       rb_resp [NB];
   logic [NB-1:0]             rx_stb_o, tx_stb_o;
   logic [31:0]               rx_out [NB], tx_out [NB];
   logic [31:0]               gpio_out [NB], gpio_ddr [NB], misc_out [NB];
   logic [2:0]                leds [NB];
   logic [`RADIO_FP_GPIO_W-1:0] fp_out, fp_ddr;

   // model state, mirrors the registers after the last rising edge
   logic [31:0] m_gpio_out [NB], m_gpio_ddr [NB], m_db_fp_out [NB], m_db_fp_ddr [NB];
   logic [31:0] m_misc_out [NB], m_led_idle [NB], m_led_act [NB], m_misc_r [NB];
   logic [1:0]  m_rx_mode [NB], m_tx_mode [NB];
   logic        m_rb_stb [NB], m_rx_stb [NB], m_tx_stb [NB];
   logic [63:0] m_rb_data [NB];
   logic [31:0] m_rx_samp [NB], m_tx_samp [NB];
   logic [23:0] m_fp_src;
   logic [`RADIO_FP_GPIO_W-1:0] m_fp_out, m_fp_ddr;

   int checks, test_errors, total_errors, tests_run, tests_failed;

   x300_radio_core u_x300_radio_core (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set0(set_in[0]), .i_set1(set_in[1]), .i_rb_req0(rb_req[0]), .i_rb_req1(rb_req[1]),
      .i_run_rx(run_rx), .i_run_tx(run_tx),
      .i_rx0(rx_in[0]), .i_rx1(rx_in[1]), .i_rx_stb(rx_stb),
      .i_tx_data0(tx_in[0]), .i_tx_data1(tx_in[1]), .i_tx_stb(tx_stb),
      .i_db0_gpio_in(gpio_in[0]), .i_db1_gpio_in(gpio_in[1]),
      .i_radio0_misc_in(misc_in[0]), .i_radio1_misc_in(misc_in[1]),
      .o_rb_resp0(rb_resp[0]), .o_rb_resp1(rb_resp[1]),
      .o_rx0(rx_out[0]), .o_rx1(rx_out[1]), .o_rx_stb(rx_stb_o),
      .o_tx0(tx_out[0]), .o_tx1(tx_out[1]), .o_tx_stb(tx_stb_o),
      .o_db0_gpio_out(gpio_out[0]), .o_db0_gpio_ddr(gpio_ddr[0]),
      .o_db1_gpio_out(gpio_out[1]), .o_db1_gpio_ddr(gpio_ddr[1]),
      .o_radio0_misc_out(misc_out[0]), .o_radio1_misc_out(misc_out[1]),
      .o_radio_led0(leds[0]), .o_radio_led1(leds[1]),
      .o_fp_gpio_out(fp_out), .o_fp_gpio_ddr(fp_ddr)
   );

   initial begin
      radio_clk = 1'b0;
      forever #2 radio_clk = ~radio_clk;
   end

   // ------------------------------
   // reference rules
   // ------------------------------
   function automatic logic [2:0] led_expect(input int b);
      if (run_rx[b] || run_tx[b]) return m_led_act[b][2:0];
      return m_led_idle[b][2:0];
   endfunction

   // swap halves on bit 0, two's complement of q on bit 1
   function automatic logic [31:0] iq_expect(input logic [31:0] s, input logic [1:0] m);
      logic [15:0] hi;
      logic [15:0] lo;
      hi = m[0] ? s[15:0] : s[31:16];
      lo = m[0] ? s[31:16] : s[15:0];
      if (m[1]) lo = ~lo + 16'd1;
      return {hi, lo};
   endfunction

   function automatic logic [7:0] pick_addr(input mode_e mode, input logic [7:0] sel);
      case (mode)
         MODE_RB: return (sel[1:0] == 2'd3) ? sel : `RADIO_RB_DB_BASE + {6'd0, sel[1:0]};
         MODE_FE: return sel[0] ? `RADIO_SR_RX_FE_BASE : `RADIO_SR_TX_FE_BASE;
         MODE_FP: begin
            if (sel[1:0] == 2'd0) return `RADIO_SR_FP_GPIO_SRC;
            if (sel[1:0] == 2'd3) return sel;    // mostly unknown
            return `RADIO_SR_DB_BASE + 8'd1 + {6'd0, sel[1:0]};   // fp out or fp ddr
         end
         default: begin
            if (sel[3:0] < 4'd7) return `RADIO_SR_DB_BASE + {4'd0, sel[3:0]};
            if (sel[3:0] == 4'd7) return `RADIO_SR_FP_GPIO_SRC;
            if (sel[3:0] == 4'd8) return `RADIO_SR_TX_FE_BASE;
            if (sel[3:0] == 4'd9) return `RADIO_SR_RX_FE_BASE;
            return sel;
         end
      endcase
   endfunction

   // ------------------------------
   // checks
   // ------------------------------
   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_outputs();
      for (int b = 0; b < NB; b++) begin
         check_value($sformatf("db%0d gpio out", b), 64'(gpio_out[b]), 64'(m_gpio_out[b]));
         check_value($sformatf("db%0d gpio ddr", b), 64'(gpio_ddr[b]), 64'(m_gpio_ddr[b]));
         check_value($sformatf("db%0d misc out", b), 64'(misc_out[b]), 64'(m_misc_out[b]));
         check_value($sformatf("db%0d leds", b), 64'(leds[b]), 64'(led_expect(b)));
         check_value($sformatf("db%0d rb stb", b), 64'(rb_resp[b].stb), 64'(m_rb_stb[b]));
         if (m_rb_stb[b]) check_value($sformatf("db%0d rb data", b), rb_resp[b].data,
                                      m_rb_data[b]);
         check_value($sformatf("rx%0d stb", b), 64'(rx_stb_o[b]), 64'(m_rx_stb[b]));
         if (m_rx_stb[b]) check_value($sformatf("rx%0d sample", b), 64'(rx_out[b]),
                                      64'(m_rx_samp[b]));
         check_value($sformatf("tx%0d stb", b), 64'(tx_stb_o[b]), 64'(m_tx_stb[b]));
         if (m_tx_stb[b]) check_value($sformatf("tx%0d sample", b), 64'(tx_out[b]),
                                      64'(m_tx_samp[b]));
      end
      check_value("fp gpio out", 64'(fp_out), 64'(m_fp_out));
      check_value("fp gpio ddr", 64'(fp_ddr), 64'(m_fp_ddr));
   endtask

   // ------------------------------
   // stimulus and model update
   // ------------------------------
   task automatic drive_inputs(input mode_e mode);
      logic [31:0] r;
      for (int b = 0; b < NB; b++) begin
         r = $urandom();
         set_in[b] = '0;
         rb_req[b] = '0;
         rx_stb[b] = 1'b0;
         tx_stb[b] = 1'b0;
         misc_in[b] = $urandom();
         gpio_in[b] = $urandom();
         if (mode == MODE_SET || mode == MODE_RB) begin
            if (r[12:11] == 2'd0) run_rx[b] = ~run_rx[b];   // random toggles
            if (r[14:13] == 2'd0) run_tx[b] = ~run_tx[b];
         end
         case (mode)
            MODE_SET: set_in[b].stb = r[0] | r[1];
            MODE_RB: begin
               set_in[b].stb = (r[2:0] == 3'd0);          // occasional register change
               rb_req[b].stb = r[16] | r[17];
               rb_req[b].addr = pick_addr(MODE_RB, r[31:24]);
            end
            MODE_FE: begin
               set_in[b].stb = r[10] & r[11];
               rx_stb[b] = r[2];
               tx_stb[b] = r[3];
               rx_in[b] = $urandom();
               tx_in[b] = $urandom();
               if (r[5:4] == 2'd0) rx_in[b][15:0] = 16'h8000;   // most negative q
               if (r[7:6] == 2'd0) rx_in[b][31:16] = 16'h8000;
               if (r[9:8] == 2'd0) tx_in[b][15:0] = 16'h8000;
            end
            MODE_FP: set_in[b].stb = r[0];
            default: ;
         endcase
         set_in[b].addr = pick_addr((mode == MODE_RB) ? MODE_SET : mode, r[23:16]);
         set_in[b].data = $urandom();
      end
   endtask

   task automatic model_step();
      logic [31:0] led_word;
      logic [7:0]  a;
      // everything sampled from the state before this edge
      for (int p = 0; p < `RADIO_FP_GPIO_W; p++) begin
         m_fp_out[p] = (m_fp_src[2*p +: 2] == 2'd0) ? m_db_fp_out[0][p] : m_db_fp_out[1][p];
         m_fp_ddr[p] = (m_fp_src[2*p +: 2] == 2'd0) ? m_db_fp_ddr[0][p] : m_db_fp_ddr[1][p];
      end
      for (int b = 0; b < NB; b++) begin
         m_rb_stb[b] = rb_req[b].stb;
         if (rb_req[b].stb) begin
            led_word = {27'd0, led_expect(b), run_tx[b], run_rx[b]};
            case (rb_req[b].addr)
               `RADIO_RB_DB_BASE:         m_rb_data[b] = {m_misc_r[b], gpio_in[b]};
               `RADIO_RB_DB_BASE + 8'd1:  m_rb_data[b] = {m_gpio_ddr[b], m_gpio_out[b]};
               `RADIO_RB_DB_BASE + 8'd2:  m_rb_data[b] = {32'd0, led_word};
               default:                   m_rb_data[b] = 64'd0;
            endcase
         end
         m_rx_stb[b] = rx_stb[b];
         m_tx_stb[b] = tx_stb[b];
         if (rx_stb[b]) m_rx_samp[b] = iq_expect(rx_in[b], m_rx_mode[b]);
         if (tx_stb[b]) m_tx_samp[b] = iq_expect(tx_in[b], m_tx_mode[b]);
         m_misc_r[b] = misc_in[b];
         a = set_in[b].addr;
         if (set_in[b].stb) begin
            if (a == `RADIO_SR_DB_BASE)         m_gpio_out[b] = set_in[b].data;
            if (a == `RADIO_SR_DB_BASE + 8'd1)  m_gpio_ddr[b] = set_in[b].data;
            if (a == `RADIO_SR_DB_BASE + 8'd2)  m_db_fp_out[b] = set_in[b].data;
            if (a == `RADIO_SR_DB_BASE + 8'd3)  m_db_fp_ddr[b] = set_in[b].data;
            if (a == `RADIO_SR_DB_BASE + 8'd4)  m_misc_out[b] = set_in[b].data;
            if (a == `RADIO_SR_DB_BASE + 8'd5)  m_led_idle[b] = set_in[b].data;
            if (a == `RADIO_SR_DB_BASE + 8'd6)  m_led_act[b] = set_in[b].data;
            if (a == `RADIO_SR_RX_FE_BASE)      m_rx_mode[b] = set_in[b].data[1:0];
            if (a == `RADIO_SR_TX_FE_BASE)      m_tx_mode[b] = set_in[b].data[1:0];
            if (b == 0 && a == `RADIO_SR_FP_GPIO_SRC) m_fp_src = set_in[b].data[23:0];
         end
      end
   endtask

   task automatic run_cycle(input mode_e mode);
      @(negedge radio_clk);
      check_outputs();
      drive_inputs(mode);
      model_step();
   endtask

   // drain any response still in flight
   task automatic wait_rb_idle();
      int n;
      n = 0;
      run_cycle(MODE_IDLE);
      while ((rb_resp[0].stb || rb_resp[1].stb) && n < IDLE_TIMEOUT) begin
         run_cycle(MODE_IDLE);
         n++;
      end
      if (n >= IDLE_TIMEOUT) begin
         $display("timeout: readback strobe still high after %0d idle cycles", n);
         test_errors++;
      end
   endtask

   task automatic run_test(input int num, input string name, input mode_e mode, input int n);
      test_errors = 0;
      for (int i = 0; i < n; i++) run_cycle(mode);
      wait_rb_idle();
      tests_run++;
      total_errors += test_errors;
      if (test_errors != 0) tests_failed++;
      $display("test %0d %s: %0s (%0d errors)", num, name,
               (test_errors == 0) ? "ok" : "bad", test_errors);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      void'($urandom(73));
      i_rst_n = 1'b0;
      run_rx = '0;
      run_tx = '0;
      rx_stb = '0;
      tx_stb = '0;
      m_fp_src = '0;
      m_fp_out = '0;
      m_fp_ddr = '0;
      for (int b = 0; b < NB; b++) begin
         set_in[b] = '0;
         rb_req[b] = '0;
         rx_in[b] = '0;
         tx_in[b] = '0;
         gpio_in[b] = '0;
         misc_in[b] = '0;
         {m_gpio_out[b], m_gpio_ddr[b], m_db_fp_out[b], m_db_fp_ddr[b]} = '0;
         {m_misc_out[b], m_led_idle[b], m_led_act[b], m_misc_r[b]} = '0;
         {m_rx_mode[b], m_tx_mode[b], m_rb_stb[b], m_rx_stb[b], m_tx_stb[b]} = '0;
         {m_rb_data[b], m_rx_samp[b], m_tx_samp[b]} = '0;
      end
      checks = 0;
      total_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (3) @(posedge radio_clk);
      @(negedge radio_clk);
      i_rst_n = 1'b1;

      run_test(1, "reset values", MODE_IDLE, 4);
      run_test(2, "settings writes", MODE_SET, CYCLES);
      run_test(3, "readback", MODE_RB, CYCLES);
      run_test(4, "iq correction", MODE_FE, CYCLES);
      run_test(5, "front-panel mux", MODE_FP, CYCLES);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== source/db_control.sv ====
`timescale 1ns/100ps
`include "radio_params.svh"

module db_control (
   input  logic                     radio_clk,
   input  logic                     i_rst_n,
   input  radio_pkg::set_bus_t      i_set,
   input  radio_pkg::rb_req_t       i_rb_req,
   input  logic                     i_run_rx,
   input  logic                     i_run_tx,
   input  logic [`RADIO_DATA_W-1:0] i_misc_in,
   input  logic [`RADIO_DATA_W-1:0] i_db_gpio_in,
   output radio_pkg::rb_resp_t      o_rb_resp,
   output radio_pkg::gpio_pair_t    o_db_gpio,
   output radio_pkg::gpio_pair_t    o_fp_gpio,
   output logic [`RADIO_DATA_W-1:0] o_misc_out,
   output logic [`RADIO_LED_W-1:0]  o_leds
);

   localparam logic [`RADIO_ADDR_W-1:0] SR_GPIO_OUT = `RADIO_SR_DB_BASE + `RADIO_DB_GPIO_OUT;
   localparam logic [`RADIO_ADDR_W-1:0] SR_GPIO_DDR = `RADIO_SR_DB_BASE + `RADIO_DB_GPIO_DDR;
   localparam logic [`RADIO_ADDR_W-1:0] SR_FP_OUT   = `RADIO_SR_DB_BASE + `RADIO_DB_FP_OUT;
   localparam logic [`RADIO_ADDR_W-1:0] SR_FP_DDR   = `RADIO_SR_DB_BASE + `RADIO_DB_FP_DDR;
   localparam logic [`RADIO_ADDR_W-1:0] SR_MISC_OUT = `RADIO_SR_DB_BASE + `RADIO_DB_MISC_OUT;
   localparam logic [`RADIO_ADDR_W-1:0] SR_LED_IDLE = `RADIO_SR_DB_BASE + `RADIO_DB_LED_IDLE;
   localparam logic [`RADIO_ADDR_W-1:0] SR_LED_ACT  = `RADIO_SR_DB_BASE + `RADIO_DB_LED_ACT;

   localparam int LED_PAD_W = `RADIO_DATA_W - `RADIO_LED_W - 2;

   logic [`RADIO_LED_W-1:0]  led_idle;
   logic [`RADIO_LED_W-1:0]  led_act;
   logic [`RADIO_DATA_W-1:0] misc_in_r;
   logic                     running;
   logic [`RADIO_DATA_W-1:0] led_word;

   // ------------------------------
   // settings registers
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_db_gpio  <= '0;
         o_fp_gpio  <= '0;
         o_misc_out <= '0;
         led_idle   <= '0;
         led_act    <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_GPIO_OUT: o_db_gpio.out <= i_set.data;
            SR_GPIO_DDR: o_db_gpio.ddr <= i_set.data;
            SR_FP_OUT:   o_fp_gpio.out <= i_set.data;   // muxed per pin downstream
            SR_FP_DDR:   o_fp_gpio.ddr <= i_set.data;
            SR_MISC_OUT: o_misc_out    <= i_set.data;
            SR_LED_IDLE: led_idle      <= i_set.data[`RADIO_LED_W-1:0];
            SR_LED_ACT:  led_act       <= i_set.data[`RADIO_LED_W-1:0];
            default: ;                                  // not ours
         endcase
      end
   end

   // misc input sampled every cycle
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         misc_in_r <= '0;
      end else begin
         misc_in_r <= i_misc_in;
      end
   end

   // leds follow the channel activity
   assign running  = i_run_rx | i_run_tx;
   assign o_leds   = running ? led_act : led_idle;
   assign led_word = {{LED_PAD_W{1'b0}}, o_leds, i_run_tx, i_run_rx};

   // ------------------------------
   // readback
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rb_resp <= '0;
      end else begin
         o_rb_resp.stb <= i_rb_req.stb;
         if (i_rb_req.stb) begin
            case (radio_pkg::rb_addr_e'(i_rb_req.addr))
               radio_pkg::RB_GPIO_MISC: o_rb_resp.data <= {misc_in_r, i_db_gpio_in};
               radio_pkg::RB_GPIO_OUT:  o_rb_resp.data <= {o_db_gpio.ddr, o_db_gpio.out};
               radio_pkg::RB_LEDS:      o_rb_resp.data <= {{`RADIO_DATA_W{1'b0}}, led_word};
               default:                 o_rb_resp.data <= '0;
            endcase
         end
      end
   end

   // back-to-back responses only after back-to-back requests
   ap_rb_pair : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      (o_rb_resp.stb && $past(o_rb_resp.stb))
         |-> ($past(i_rb_req.stb) && $past(i_rb_req.stb, 2)));

endmodule

// ==== source/fe_control.sv ====
`timescale 1ns/100ps
`include "radio_params.svh"

module fe_control (
   input  logic                     radio_clk,
   input  logic                     i_rst_n,
   input  radio_pkg::set_bus_t      i_set,
   input  logic                     i_rx_stb,
   input  logic [`RADIO_SAMP_W-1:0] i_rx_samp,
   input  logic                     i_tx_stb,
   input  logic [`RADIO_SAMP_W-1:0] i_tx_samp,
   output logic                     o_rx_stb,
   output logic [`RADIO_SAMP_W-1:0] o_rx_samp,
   output logic                     o_tx_stb,
   output logic [`RADIO_SAMP_W-1:0] o_tx_samp
);

   localparam logic [`RADIO_ADDR_W-1:0] SR_RX_MODE = `RADIO_SR_RX_FE_BASE;
   localparam logic [`RADIO_ADDR_W-1:0] SR_TX_MODE = `RADIO_SR_TX_FE_BASE;

   // mode bit 0 swaps i/q, bit 1 negates q
   logic [1:0] rx_mode;
   logic [1:0] tx_mode;

   // iq correction, same for both directions
   function automatic logic [`RADIO_SAMP_W-1:0] fe_correct(
      input logic [`RADIO_SAMP_W-1:0] samp,
      input logic [1:0]               mode
   );
      logic [`RADIO_HALF_W-1:0] samp_i;
      logic [`RADIO_HALF_W-1:0] samp_q;
      samp_i = samp[`RADIO_SAMP_W-1:`RADIO_HALF_W];
      samp_q = samp[`RADIO_HALF_W-1:0];
      if (mode[0]) begin
         samp_i = samp[`RADIO_HALF_W-1:0];
         samp_q = samp[`RADIO_SAMP_W-1:`RADIO_HALF_W];
      end
      if (mode[1]) begin
         samp_q = -samp_q;   // 16-bit wrap, -32768 maps to itself
      end
      return {samp_i, samp_q};
   endfunction

   // ------------------------------
   // mode registers
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rx_mode <= '0;
         tx_mode <= '0;
      end else if (i_set.stb) begin
         if (i_set.addr == SR_RX_MODE) rx_mode <= i_set.data[1:0];
         if (i_set.addr == SR_TX_MODE) tx_mode <= i_set.data[1:0];
      end
   end

   // ------------------------------
   // sample path
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rx_stb  <= 1'b0;
         o_rx_samp <= '0;
         o_tx_stb  <= 1'b0;
         o_tx_samp <= '0;
      end else begin
         o_rx_stb <= i_rx_stb;
         o_tx_stb <= i_tx_stb;
         if (i_rx_stb) o_rx_samp <= fe_correct(i_rx_samp, rx_mode);
         if (i_tx_stb) o_tx_samp <= fe_correct(i_tx_samp, tx_mode);
      end
   end

   // one cycle of latency on the rx strobe
   ap_rx_stb_lat : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $past(i_rst_n) |-> (o_rx_stb == $past(i_rx_stb)));

endmodule

// ==== source/fp_gpio_mux.sv ====
`timescale 1ns/100ps
`include "radio_params.svh"

module fp_gpio_mux (
   input  logic                        radio_clk,
   input  logic                        i_rst_n,
   input  radio_pkg::set_bus_t         i_set,
   input  radio_pkg::gpio_pair_t       i_fp_db0,
   input  radio_pkg::gpio_pair_t       i_fp_db1,
   output logic [`RADIO_FP_GPIO_W-1:0] o_fp_gpio_out,
   output logic [`RADIO_FP_GPIO_W-1:0] o_fp_gpio_ddr
);

   localparam int SRC_W = 2 * `RADIO_FP_GPIO_W;

   logic [SRC_W-1:0] fp_src;   // two bits per pin

   // ------------------------------
   // source select register
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         fp_src <= '0;
      end else if (i_set.stb && (i_set.addr == `RADIO_SR_FP_GPIO_SRC)) begin
         fp_src <= i_set.data[SRC_W-1:0];
      end
   end

   // ------------------------------
   // per-pin mux
   // ------------------------------
   // 0 picks db0, anything else db1
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         for (int p = 0; p < `RADIO_FP_GPIO_W; p++) begin
            if (fp_src[2*p +: 2] == 2'd0) begin
               o_fp_gpio_out[p] <= i_fp_db0.out[p];
               o_fp_gpio_ddr[p] <= i_fp_db0.ddr[p];
            end else begin
               o_fp_gpio_out[p] <= i_fp_db1.out[p];
               o_fp_gpio_ddr[p] <= i_fp_db1.ddr[p];
            end
         end
      end
   end

endmodule

// ==== source/radio_params.svh ====
`ifndef RADIO_PARAMS_SVH
`define RADIO_PARAMS_SVH

// ------------------------------
// counts and widths
// ------------------------------
`define RADIO_NUM_DBOARDS     2
`define RADIO_DATA_W          32
`define RADIO_SAMP_W          32       // i in high half, q in low half
`define RADIO_HALF_W          16
`define RADIO_FP_GPIO_W       12
`define RADIO_ADDR_W          8
`define RADIO_RB_W            64
`define RADIO_LED_W           3

// ------------------------------
// settings bus map
// ------------------------------
`define RADIO_SR_FP_GPIO_SRC  8'd150
`define RADIO_SR_DB_BASE      8'd160
`define RADIO_SR_TX_FE_BASE   8'd208
`define RADIO_SR_RX_FE_BASE   8'd224

// db_control offsets from the db base
`define RADIO_DB_GPIO_OUT     8'd0
`define RADIO_DB_GPIO_DDR     8'd1
`define RADIO_DB_FP_OUT       8'd2
`define RADIO_DB_FP_DDR       8'd3
`define RADIO_DB_MISC_OUT     8'd4
`define RADIO_DB_LED_IDLE     8'd5
`define RADIO_DB_LED_ACT      8'd6

// readback map
`define RADIO_RB_DB_BASE      8'd16

`endif

// ==== source/radio_pkg.sv ====
`include "radio_params.svh"

package radio_pkg;

   // ------------------------------
   // settings and readback buses
   // ------------------------------

   // one register write per cycle with stb high
   typedef struct packed {
      logic                     stb;
      logic [`RADIO_ADDR_W-1:0] addr;
      logic [`RADIO_DATA_W-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic                     stb;
      logic [`RADIO_ADDR_W-1:0] addr;
   } rb_req_t;

   // stb pulses one cycle after the request
   typedef struct packed {
      logic                     stb;
      logic [`RADIO_RB_W-1:0]   data;
   } rb_resp_t;

   // ------------------------------
   // gpio
   // ------------------------------
   typedef struct packed {
      logic [`RADIO_DATA_W-1:0] out;
      logic [`RADIO_DATA_W-1:0] ddr;   // 1 = pin driven
   } gpio_pair_t;

   // db_control readback addresses
   typedef enum logic [`RADIO_ADDR_W-1:0] {
      RB_GPIO_MISC = `RADIO_RB_DB_BASE,           // {misc in, db gpio in}
      RB_GPIO_OUT  = `RADIO_RB_DB_BASE + 8'd1,    // {gpio ddr, gpio out}
      RB_LEDS      = `RADIO_RB_DB_BASE + 8'd2     // {0, leds, run_tx, run_rx}
   } rb_addr_e;

endpackage

// ==== source/x300_radio_core.sv ====
`timescale 1ns/100ps
`include "radio_params.svh"

module x300_radio_core (
   input  logic                          radio_clk,
   input  logic                          i_rst_n,
   input  radio_pkg::set_bus_t           i_set0,
   input  radio_pkg::set_bus_t           i_set1,
   input  radio_pkg::rb_req_t            i_rb_req0,
   input  radio_pkg::rb_req_t            i_rb_req1,
   input  logic [`RADIO_NUM_DBOARDS-1:0] i_run_rx,
   input  logic [`RADIO_NUM_DBOARDS-1:0] i_run_tx,
   input  logic [`RADIO_SAMP_W-1:0]      i_rx0,
   input  logic [`RADIO_SAMP_W-1:0]      i_rx1,
   input  logic [`RADIO_NUM_DBOARDS-1:0] i_rx_stb,
   input  logic [`RADIO_SAMP_W-1:0]      i_tx_data0,
   input  logic [`RADIO_SAMP_W-1:0]      i_tx_data1,
   input  logic [`RADIO_NUM_DBOARDS-1:0] i_tx_stb,
   input  logic [`RADIO_DATA_W-1:0]      i_db0_gpio_in,
   input  logic [`RADIO_DATA_W-1:0]      i_db1_gpio_in,
   input  logic [`RADIO_DATA_W-1:0]      i_radio0_misc_in,
   input  logic [`RADIO_DATA_W-1:0]      i_radio1_misc_in,
   output radio_pkg::rb_resp_t           o_rb_resp0,
   output radio_pkg::rb_resp_t           o_rb_resp1,
   output logic [`RADIO_SAMP_W-1:0]      o_rx0,
   output logic [`RADIO_SAMP_W-1:0]      o_rx1,
   output logic [`RADIO_NUM_DBOARDS-1:0] o_rx_stb,
   output logic [`RADIO_SAMP_W-1:0]      o_tx0,
   output logic [`RADIO_SAMP_W-1:0]      o_tx1,
   output logic [`RADIO_NUM_DBOARDS-1:0] o_tx_stb,
   output logic [`RADIO_DATA_W-1:0]      o_db0_gpio_out,
   output logic [`RADIO_DATA_W-1:0]      o_db0_gpio_ddr,
   output logic [`RADIO_DATA_W-1:0]      o_db1_gpio_out,
   output logic [`RADIO_DATA_W-1:0]      o_db1_gpio_ddr,
   output logic [`RADIO_DATA_W-1:0]      o_radio0_misc_out,
   output logic [`RADIO_DATA_W-1:0]      o_radio1_misc_out,
   output logic [`RADIO_LED_W-1:0]       o_radio_led0,
   output logic [`RADIO_LED_W-1:0]       o_radio_led1,
   output logic [`RADIO_FP_GPIO_W-1:0]   o_fp_gpio_out,
   output logic [`RADIO_FP_GPIO_W-1:0]   o_fp_gpio_ddr
);

   radio_pkg::gpio_pair_t db_gpio [`RADIO_NUM_DBOARDS];   // daughterboard pins
   radio_pkg::gpio_pair_t fp_gpio [`RADIO_NUM_DBOARDS];   // front-panel candidates

   // ------------------------------
   // daughterboard control
   // ------------------------------
   db_control u_db_control0 (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set(i_set0), .i_rb_req(i_rb_req0),
      .i_run_rx(i_run_rx[0]), .i_run_tx(i_run_tx[0]),
      .i_misc_in(i_radio0_misc_in), .i_db_gpio_in(i_db0_gpio_in),
      .o_rb_resp(o_rb_resp0), .o_db_gpio(db_gpio[0]), .o_fp_gpio(fp_gpio[0]),
      .o_misc_out(o_radio0_misc_out), .o_leds(o_radio_led0)
   );

   db_control u_db_control1 (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set(i_set1), .i_rb_req(i_rb_req1),
      .i_run_rx(i_run_rx[1]), .i_run_tx(i_run_tx[1]),
      .i_misc_in(i_radio1_misc_in), .i_db_gpio_in(i_db1_gpio_in),
      .o_rb_resp(o_rb_resp1), .o_db_gpio(db_gpio[1]), .o_fp_gpio(fp_gpio[1]),
      .o_misc_out(o_radio1_misc_out), .o_leds(o_radio_led1)
   );

   assign o_db0_gpio_out = db_gpio[0].out;
   assign o_db0_gpio_ddr = db_gpio[0].ddr;
   assign o_db1_gpio_out = db_gpio[1].out;
   assign o_db1_gpio_ddr = db_gpio[1].ddr;

   // ------------------------------
   // front ends
   // ------------------------------
   fe_control u_fe_control0 (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n), .i_set(i_set0),
      .i_rx_stb(i_rx_stb[0]), .i_rx_samp(i_rx0),
      .i_tx_stb(i_tx_stb[0]), .i_tx_samp(i_tx_data0),
      .o_rx_stb(o_rx_stb[0]), .o_rx_samp(o_rx0),
      .o_tx_stb(o_tx_stb[0]), .o_tx_samp(o_tx0)
   );

   fe_control u_fe_control1 (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n), .i_set(i_set1),
      .i_rx_stb(i_rx_stb[1]), .i_rx_samp(i_rx1),
      .i_tx_stb(i_tx_stb[1]), .i_tx_samp(i_tx_data1),
      .o_rx_stb(o_rx_stb[1]), .o_rx_samp(o_rx1),
      .o_tx_stb(o_tx_stb[1]), .o_tx_samp(o_tx1)
   );

   // source register lives on board 0's bus
   fp_gpio_mux u_fp_gpio_mux (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n), .i_set(i_set0),
      .i_fp_db0(fp_gpio[0]), .i_fp_db1(fp_gpio[1]),
      .o_fp_gpio_out(o_fp_gpio_out), .o_fp_gpio_ddr(o_fp_gpio_ddr)
   );

endmodule

// ==== tb.f ====
+incdir+source
source/radio_pkg.sv
source/db_control.sv
source/fe_control.sv
source/fp_gpio_mux.sv
source/x300_radio_core.sv
sim/tb_x300_radio_core.sv
